//--- common/qr_pkg.sv
/*
 * qr_pkg: matrix geometry and control types for the QR engine
 */
package qr_pkg;

   // matrix shape
   localparam int num_rows = 8;
   localparam int num_cols = 4;

   // row and column addressing
   typedef logic [$clog2(num_rows)-1:0] row_idx_t;
   typedef logic [$clog2(num_cols)-1:0] col_idx_t;

   // sequencer states
   typedef enum logic [1:0] {
      st_idle,
      st_load,
      st_calc,
      st_out
   } state_t;

endpackage

//--- common/cordic_pkg.sv
/*
 * cordic_pkg: iteration, direction and gain definitions for the Givens CORDIC
 */
package cordic_pkg;

   // micro-rotations per operation, two per clock
   localparam int num_iter       = 8;
   localparam int iter_per_cycle = 2;

   typedef logic [$clog2(num_iter)-1:0] iter_t;
   typedef logic [num_iter-1:0]         dir_t;

   // gain correction, about 0.6074 in 1.10 fixed point
   localparam int                     k_w     = 11;
   localparam int                     k_frac  = 10;
   localparam logic signed [k_w-1:0]  k_scale = 11'sd622;

   typedef enum logic {
      mode_vector,
      mode_rotate
   } cordic_mode_t;

endpackage

//--- common/givens_if.sv
/*
 * givens_if: one Givens operation between sequencer, matrix store and CORDIC engine
 */
`timescale 1ns/10ps

interface givens_if import cordic_pkg::*; #(
   parameter int data_w = 13
) ();

   // operation request
   logic                     start;
   cordic_mode_t             mode;

   // operand pair from the store
   logic signed [data_w-1:0] op_x;
   logic signed [data_w-1:0] op_y;

   // gain-corrected results, valid with done
   logic signed [data_w-1:0] res_x;
   logic signed [data_w-1:0] res_y;
   logic                     done;

   modport seq (output start, output mode, input done);

   modport store (output op_x, output op_y, input res_x, input res_y);

   modport engine (
      input  start, input  mode, input  op_x, input  op_y,
      output res_x, output res_y, output done
   );

endinterface

//--- hw/cordic/givens_cordic.sv
/*
 * givens_cordic: folded CORDIC for Givens vectoring and rotation, two steps per clock
 */
`timescale 1ns/10ps

module givens_cordic import cordic_pkg::*; #(
   parameter int data_w = 13
) (
   input  logic     clk,
   input  logic     rst_n,
   givens_if.engine gv
);

   // two guard bits cover the CORDIC gain on a vector of two elements
   localparam int    ext_w     = data_w + 2;
   localparam iter_t last_iter = iter_t'(num_iter - iter_per_cycle);

   logic                          busy_q;
   iter_t                         iter_q;
   dir_t                          dir_q;
   cordic_mode_t                  mode_q;
   logic signed [ext_w-1:0]       x_q;
   logic signed [ext_w-1:0]       y_q;
   logic signed [ext_w-1:0]       x_s [iter_per_cycle+1];
   logic signed [ext_w-1:0]       y_s [iter_per_cycle+1];
   logic [iter_per_cycle-1:0]     d_s;
   iter_t                         sh  [iter_per_cycle];
   logic signed [ext_w+k_w-1:0]   prod_x;
   logic signed [ext_w+k_w-1:0]   prod_y;

   // micro-rotation chain for this cycle
   always_comb begin
      x_s[0] = x_q;
      y_s[0] = y_q;
      for (int k = 0; k < iter_per_cycle; k++) begin
         sh[k] = iter_q + iter_t'(k);
         // equal signs means subtract from y
         if (mode_q == mode_vector) begin
            d_s[k] = (x_s[k][ext_w-1] == y_s[k][ext_w-1]);
         end else begin
            d_s[k] = dir_q[sh[k]];
         end
         if (d_s[k]) begin
            x_s[k+1] = x_s[k] + (y_s[k] >>> sh[k]);
            y_s[k+1] = y_s[k] - (x_s[k] >>> sh[k]);
         end else begin
            x_s[k+1] = x_s[k] - (y_s[k] >>> sh[k]);
            y_s[k+1] = y_s[k] + (x_s[k] >>> sh[k]);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         iter_q <= '0;
         dir_q  <= '0;
         mode_q <= mode_vector;
      end else if (gv.start) begin
         busy_q <= 1'b1;
         iter_q <= '0;
         mode_q <= gv.mode;
      end else if (busy_q) begin
         iter_q <= iter_q + iter_t'(iter_per_cycle);
         if (gv.done) begin
            busy_q <= 1'b0;
         end
         // directions kept for the rotations that follow
         if (mode_q == mode_vector) begin
            for (int k = 0; k < iter_per_cycle; k++) begin
               dir_q[sh[k]] <= d_s[k];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (gv.start) begin
         x_q <= ext_w'(gv.op_x);
         y_q <= ext_w'(gv.op_y);
      end else if (busy_q) begin
         x_q <= x_s[iter_per_cycle];
         y_q <= y_s[iter_per_cycle];
      end
   end

   // gain correction on the last pair of steps
   assign prod_x = x_s[iter_per_cycle] * k_scale;
   assign prod_y = y_s[iter_per_cycle] * k_scale;

   assign gv.done  = busy_q && (iter_q == last_iter);
   assign gv.res_x = data_w'(prod_x >>> k_frac);
   assign gv.res_y = data_w'(prod_y >>> k_frac);

endmodule

//--- hw/matrix_store.sv
/*
 * matrix_store: 8x4 element array with row load, operand pair access and readout
 */
`timescale 1ns/10ps

module matrix_store import qr_pkg::*; #(
   parameter int data_w = 13
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       load_en,
   input  row_idx_t                   load_row,
   input  logic [num_cols*data_w-1:0] in,
   input  row_idx_t                   row_hi,
   input  row_idx_t                   row_lo,
   input  col_idx_t                   col,
   input  logic                       wr_en,
   givens_if.store                    gv,
   input  row_idx_t                   rd_row,
   input  logic                       out_valid,
   output logic [num_cols*data_w-1:0] out
);

   logic signed [data_w-1:0] mat_q [num_rows][num_cols];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < num_rows; r++) begin
            for (int c = 0; c < num_cols; c++) begin
               mat_q[r][c] <= '0;
            end
         end
      end else if (load_en) begin
         // element j sits at bit j*data_w
         for (int c = 0; c < num_cols; c++) begin
            mat_q[load_row][c] <= in[c*data_w +: data_w];
         end
      end else if (wr_en) begin
         // x goes back to the upper row, y to the lower
         mat_q[row_hi][col] <= gv.res_x;
         mat_q[row_lo][col] <= gv.res_y;
      end
   end

   // operand pair for the engine
   assign gv.op_x = mat_q[row_hi][col];
   assign gv.op_y = mat_q[row_lo][col];

   always_comb begin
      for (int c = 0; c < num_cols; c++) begin
         out[c*data_w +: data_w] = out_valid ? mat_q[rd_row][c] : '0;
      end
   end

endmodule

//--- hw/qr_sequencer.sv
/*
 * qr_sequencer: schedules row loading, every Givens operation and the row readout
 */
`timescale 1ns/10ps

module qr_sequencer import qr_pkg::*, cordic_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     valid,
   givens_if.seq    gv,
   output logic     load_en,
   output row_idx_t load_row,
   output row_idx_t row_hi,
   output row_idx_t row_lo,
   output col_idx_t col,
   output logic     wr_en,
   output row_idx_t rd_row,
   output logic     out_valid
);

   localparam row_idx_t last_row   = row_idx_t'(num_rows - 1);
   localparam col_idx_t last_col   = col_idx_t'(num_cols - 1);
   // last pivot with columns to its right
   localparam col_idx_t last_pivot = col_idx_t'(num_cols - 2);

   state_t   state_q;
   row_idx_t beat_q;
   row_idx_t out_cnt_q;
   col_idx_t c_q;
   row_idx_t r_q;
   col_idx_t j_q;
   logic     start_q;
   logic     last_beat;
   logic     at_last_col;
   logic     at_last_pair;
   logic     last_op;

   assign load_en   = valid && (state_q == st_idle || state_q == st_load);
   assign last_beat = load_en && (beat_q == '0);

   // schedule position
   assign at_last_col  = (j_q == last_col);
   assign at_last_pair = (r_q == row_idx_t'(c_q) + row_idx_t'(1));
   assign last_op      = at_last_col && at_last_pair && (c_q == last_pivot);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
      end else begin
         case (state_q)
            st_idle: if (load_en) state_q <= st_load;
            st_load: if (last_beat) state_q <= st_calc;
            st_calc: if (gv.done && last_op) state_q <= st_out;
            st_out:  if (out_cnt_q == '0) state_q <= st_idle;
            default: state_q <= st_idle;
         endcase
      end
   end

   // input rows arrive 7 first, output leaves the same way
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_q    <= last_row;
         out_cnt_q <= last_row;
      end else begin
         if (load_en) begin
            beat_q <= (beat_q == '0) ? last_row : beat_q - row_idx_t'(1);
         end
         if (state_q == st_out) begin
            out_cnt_q <= (out_cnt_q == '0) ? last_row : out_cnt_q - row_idx_t'(1);
         end
      end
   end

   // pivot column c, lower row r, target column j
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         c_q <= '0;
         r_q <= last_row;
         j_q <= '0;
      end else if (gv.done) begin
         if (!at_last_col) begin
            j_q <= j_q + col_idx_t'(1);
         end else if (!at_last_pair) begin
            r_q <= r_q - row_idx_t'(1);
            j_q <= c_q;
         end else if (c_q != last_pivot) begin
            c_q <= c_q + col_idx_t'(1);
            r_q <= last_row;
            j_q <= c_q + col_idx_t'(1);
         end else begin
            // ready for the next matrix
            c_q <= '0;
            r_q <= last_row;
            j_q <= '0;
         end
      end
   end

   // next operation one cycle after done, first one after the last beat
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start_q <= 1'b0;
      end else begin
         start_q <= last_beat || (gv.done && !last_op);
      end
   end

   assign gv.start = start_q;
   assign gv.mode  = (j_q == c_q) ? mode_vector : mode_rotate;

   assign row_hi    = r_q - row_idx_t'(1);
   assign row_lo    = r_q;
   assign col       = j_q;
   assign wr_en     = gv.done && (state_q == st_calc);
   assign load_row  = beat_q;
   assign rd_row    = out_cnt_q;
   assign out_valid = (state_q == st_out);

endmodule

//--- hw/qr_cordic_top.sv
/*
 * qr_cordic_top: 8x4 QR decomposition by Givens rotations on one folded CORDIC
 */
`timescale 1ns/10ps

module qr_cordic_top import qr_pkg::*; #(
   parameter int data_w = 13
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       valid,
   input  logic [num_cols*data_w-1:0] in,
   output logic                       out_valid,
   output logic [num_cols*data_w-1:0] out
);

   // sequencer to store control
   logic     load_en;
   row_idx_t load_row;
   row_idx_t row_hi;
   row_idx_t row_lo;
   col_idx_t col;
   logic     wr_en;
   row_idx_t rd_row;

   givens_if #(.data_w(data_w)) givens_if_i ();

   qr_sequencer qr_sequencer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .gv        (givens_if_i.seq),
      .load_en   (load_en),
      .load_row  (load_row),
      .row_hi    (row_hi),
      .row_lo    (row_lo),
      .col       (col),
      .wr_en     (wr_en),
      .rd_row    (rd_row),
      .out_valid (out_valid)
   );

   matrix_store #(.data_w(data_w)) matrix_store_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .load_en   (load_en),
      .load_row  (load_row),
      .in        (in),
      .row_hi    (row_hi),
      .row_lo    (row_lo),
      .col       (col),
      .wr_en     (wr_en),
      .gv        (givens_if_i.store),
      .rd_row    (rd_row),
      .out_valid (out_valid),
      .out       (out)
   );

   // shared for vectoring and rotation
   givens_cordic #(.data_w(data_w)) givens_cordic_i (
      .clk   (clk),
      .rst_n (rst_n),
      .gv    (givens_if_i.engine)
   );

endmodule

//--- dv/qr_cordic_assert.sv
/*
 * qr_cordic_assert: protocol checks on the QR engine output and the Givens handshake
 */
`timescale 1ns/10ps

module qr_cordic_assert import qr_pkg::*; #(
   parameter int data_w = 13
) (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       out_valid,
   input logic [num_cols*data_w-1:0] out,
   input logic                       start,
   input logic                       done
);

   // one operation between start and done
   logic op_busy_q;

   // assertion failures so far
   int   fail_cnt = 0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_busy_q <= 1'b0;
      end else if (start) begin
         op_busy_q <= 1'b1;
      end else if (done) begin
         op_busy_q <= 1'b0;
      end
   end

   out_valid_len: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out_valid) |-> out_valid [*num_rows] ##1 !out_valid)
      else begin
         $error("out_valid was not high for exactly %0d cycles", num_rows);
         fail_cnt++;
      end

   out_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !out_valid |-> (out == '0))
      else begin
         $error("out is nonzero while out_valid is low");
         fail_cnt++;
      end

   start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> !op_busy_q)
      else begin
         $error("start raised while an operation is outstanding");
         fail_cnt++;
      end

   done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> ##4 done)
      else begin
         $error("done did not follow start after 4 cycles");
         fail_cnt++;
      end

endmodule

//--- dv/tb_qr_cordic.sv
/*
 * tb_qr_cordic: testbench for the QR engine, checks every output row against a reference model
 */
`timescale 1ns/10ps

module tb_qr_cordic import qr_pkg::*; ();

   localparam int data_w       = 13;
   localparam int ext_w        = data_w + 2;
   localparam int micro_steps  = 8;
   localparam int gain         = 622;
   localparam int gain_frac    = 10;
   localparam int clk_period   = 20;
   localparam int reset_cycles = 5;
   localparam int idle_cycles  = 10;
   localparam int num_mats     = 10;

   logic                       clk = 1'b0;
   logic                       rst_n;
   logic                       valid;
   logic [num_cols*data_w-1:0] in;
   logic                       out_valid;
   logic [num_cols*data_w-1:0] out;

   integer seed;
   int     in_mat  [num_rows][num_cols];
   int     exp_mat [num_rows][num_cols];
   int     mats_checked = 0;
   string  test_name;

   always #(clk_period / 2) clk = ~clk;

   qr_cordic_top #(.data_w(data_w)) qr_cordic_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .in        (in),
      .out_valid (out_valid),
      .out       (out)
   );

   bind qr_cordic_top qr_cordic_assert #(.data_w(data_w)) qr_cordic_assert_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .out_valid (out_valid),
      .out       (out),
      .start     (givens_if_i.start),
      .done      (givens_if_i.done)
   );

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   // keep the low w bits, sign extended
   function automatic int wrap_bits(input int v, input int w);
      return (v <<< (32 - w)) >>> (32 - w);
   endfunction

   // expected R: Givens pairs from the bottom up, x to the upper row and y to the lower
   function automatic void reference_qr();
      int              m [num_rows][num_cols];
      int              x;
      int              y;
      int              nx;
      int              ny;
      logic [micro_steps-1:0] dirs;
      m = in_mat;
      dirs = '0;
      for (int c = 0; c < num_cols - 1; c++) begin
         for (int r = num_rows - 1; r > c; r--) begin
            for (int j = c; j < num_cols; j++) begin
               x = m[r-1][j];
               y = m[r][j];
               for (int i = 0; i < micro_steps; i++) begin
                  // vectoring on the pivot column, replay for the others
                  if (j == c) begin
                     dirs[i] = ((x < 0) == (y < 0));
                  end
                  if (dirs[i]) begin
                     nx = x + (y >>> i);
                     ny = y - (x >>> i);
                  end else begin
                     nx = x - (y >>> i);
                     ny = y + (x >>> i);
                  end
                  x = wrap_bits(nx, ext_w);
                  y = wrap_bits(ny, ext_w);
               end
               m[r-1][j] = wrap_bits((x * gain) >>> gain_frac, data_w);
               m[r][j]   = wrap_bits((y * gain) >>> gain_frac, data_w);
            end
         end
      end
      exp_mat = m;
   endfunction

   function automatic int rand_elem();
      return $random(seed) % 256;
   endfunction

   function automatic int neg_elem();
      int v;
      v = rand_elem();
      if (v > 0) begin
         v = -v;
      end else if (v == 0) begin
         v = -1;
      end
      return v;
   endfunction

   function automatic void fill_random();
      for (int r = 0; r < num_rows; r++) begin
         for (int c = 0; c < num_cols; c++) begin
            in_mat[r][c] = rand_elem();
         end
      end
   endfunction

   function automatic logic [num_cols*data_w-1:0] pack_row(input int r);
      logic [num_cols*data_w-1:0] v;
      int                         el;
      for (int c = 0; c < num_cols; c++) begin
         el = in_mat[r][c];
         v[c*data_w +: data_w] = el[data_w-1:0];
      end
      return v;
   endfunction

   function automatic logic [num_cols*data_w-1:0] random_row();
      logic [num_cols*data_w-1:0] v;
      int                         el;
      for (int c = 0; c < num_cols; c++) begin
         el = rand_elem();
         v[c*data_w +: data_w] = el[data_w-1:0];
      end
      return v;
   endfunction

   // rows 7 down to 0, then optional junk beats while the engine computes
   task automatic load_matrix(input int extra);
      for (int r = num_rows - 1; r >= 0; r--) begin
         @(posedge clk);
         valid <= 1'b1;
         in    <= pack_row(r);
      end
      for (int k = 0; k < extra; k++) begin
         @(posedge clk);
         valid <= 1'b1;
         in    <= random_row();
      end
      @(posedge clk);
      valid <= 1'b0;
      in    <= '0;
   endtask

   task automatic run_matrix(input int extra);
      int target;
      target = mats_checked + 1;
      reference_qr();
      load_matrix(extra);
      wait (mats_checked == target);
   endtask

   initial begin : compare_outputs
      logic signed [data_w-1:0] act;
      int                       row;
      forever begin
         @(negedge clk);
         if (out_valid) begin
            for (int k = 0; k < num_rows; k++) begin
               row = num_rows - 1 - k;
               assert (out_valid)
               else fail_stop($sformatf("%s: out_valid dropped before row %0d", test_name, row));
               for (int c = 0; c < num_cols; c++) begin
                  act = out[c*data_w +: data_w];
                  assert (int'(act) == exp_mat[row][c])
                  else fail_stop($sformatf("error %s row %0d col %0d expected %0d actual %0d",
                                           test_name, row, c, exp_mat[row][c], int'(act)));
               end
               @(negedge clk);
            end
            mats_checked++;
         end
      end
   end

   // protocol assertions in the bound checker
   initial begin : assert_watch
      wait (qr_cordic_top_i.qr_cordic_assert_i.fail_cnt != 0);
      fail_stop("a protocol assertion on the DUT failed");
   end

   initial begin : watchdog
      #((num_mats * 500 + reset_cycles + idle_cycles) * clk_period);
      fail_stop("timeout: the expected output rows did not all arrive in time");
   end

   initial begin : main_sequence
      rst_n     = 1'b0;
      valid     = 1'b0;
      in        = '0;
      seed      = 32'h7bd74370;
      test_name = "reset";
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;

      test_name = "idle_after_reset";
      repeat (idle_cycles) begin
         @(negedge clk);
         assert (!out_valid && out == '0)
         else fail_stop("out_valid or out became active before any matrix was loaded");
      end

      // only rows 0 and 1 carry the first column
      test_name = "sparse_col0";
      fill_random();
      for (int r = 2; r < num_rows; r++) begin
         in_mat[r][0] = 0;
      end
      in_mat[0][0] = 181;
      in_mat[1][0] = -97;
      run_matrix(0);

      test_name = "random";
      repeat (4) begin
         fill_random();
         run_matrix(0);
      end

      test_name = "negative_pivots";
      repeat (2) begin
         fill_random();
         for (int r = 0; r < num_rows; r++) begin
            in_mat[r][0] = neg_elem();
         end
         for (int c = 1; c < num_cols; c++) begin
            in_mat[c][c] = neg_elem();
         end
         run_matrix(0);
      end

      test_name = "back_to_back";
      repeat (3) begin
         fill_random();
         run_matrix(5);
      end

      if (qr_cordic_top_i.qr_cordic_assert_i.fail_cnt == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         fail_stop("a protocol assertion on the DUT failed during the run");
      end
   end

endmodule

//--- list.f
common/qr_pkg.sv
common/cordic_pkg.sv
common/givens_if.sv
hw/cordic/givens_cordic.sv
hw/matrix_store.sv
hw/qr_sequencer.sv
hw/qr_cordic_top.sv
dv/qr_cordic_assert.sv
dv/tb_qr_cordic.sv

//--- Bender.yml
package:
  name: qr_cordic

sources:
  - files:
      - common/qr_pkg.sv
      - common/cordic_pkg.sv
      - common/givens_if.sv
      - hw/cordic/givens_cordic.sv
      - hw/matrix_store.sv
      - hw/qr_sequencer.sv
      - hw/qr_cordic_top.sv
  - target: test
    files:
      - dv/qr_cordic_assert.sv
      - dv/tb_qr_cordic.sv
